//--- Makefile
# Verilator build and run for the tilemap address generator

VERILATOR ?= verilator
TOP ?= tilemapTb
FILELIST ?= sources.f
OBJDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMFLAGS ?=

.PHONY: sim clean

# the testbench ends every failure in $fatal, so the exit status is the verdict
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) $(SIMFLAGS)

clean:
	rm -rf $(OBJDIR)

//--- dv/tilemapTb.sv
`timescale 1ns/10ps

module tilemapTb;
	import tilemapPkg::*;

	// one line is 384 clocks, 192 pixel pairs
	localparam int linePeriod = 384;
	localparam int linesPerFrame = 16;
	localparam int readyTimeout = 16;
	// ga from fetches older than a write is skipped
	localparam int quietCycles = 8;

	logic CLK_6M;
	logic rstN;
	logic pSel;
	logic pEnable;
	logic pWrite;
	logic [apbAddrW-1:0] pAddr;
	logic [7:0] pWData;
	logic hSync;
	logic vSync;
	logic [7:0] pRData;
	logic pReady;
	logic [gaW-1:0] ga;
	logic gaLayer;
	logic [priW-1:0] gaPri;
	logic nibbleStrobe;

	// tile ram and register contents as the cpu wrote them
	logic [7:0] mirror [0:(1 << ramAddrW)-1];
	logic [hScrollW-1:0] hScr [0:1];
	logic [vScrollW-1:0] vScr [0:1];
	logic [priW-1:0] priCopy [0:1];
	// video position tracked from the sync inputs
	logic [hScrollW-1:0] hPosT;
	logic [vScrollW-1:0] vPosT;
	logic layerT;
	logic hPrev;
	logic vPrev;
	int cycleCnt;
	int lastWr;
	int gaChecks;
	logic checking;
	logic [31:0] lcgState;

	tilemapTop DUT (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.pSel(pSel),
		.pEnable(pEnable),
		.pWrite(pWrite),
		.pAddr(pAddr),
		.pWData(pWData),
		.hSync(hSync),
		.vSync(vSync),
		.pRData(pRData),
		.pReady(pReady),
		.ga(ga),
		.gaLayer(gaLayer),
		.gaPri(gaPri),
		.nibbleStrobe(nibbleStrobe)
	);

	initial begin
		CLK_6M = 1'b0;
		forever #10 CLK_6M = ~CLK_6M;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// cpu view of a completed write
	function automatic void modelWrite(input logic [apbAddrW-1:0] addr, input logic [7:0] data);
		logic l;
		l = addr[2];
		lastWr = cycleCnt;
		if (addr < regBase) begin
			mirror[addr[ramAddrW-1:0]] = data;
		end else begin
			case (addr[1:0])
				2'd0: hScr[l][7:0] = data;
				// scroll bit 8 low, priority above
				2'd1: begin
					hScr[l][8] = data[0];
					priCopy[l] = data[3:1];
				end
				2'd2: vScr[l] = data;
				default: ;
			endcase
		end
	endfunction

	function automatic logic [7:0] regExpect(input logic [apbAddrW-1:0] addr);
		logic l;
		l = addr[2];
		case (addr[1:0])
			2'd0: return hScr[l][7:0];
			2'd1: return {4'b0, priCopy[l], hScr[l][8]};
			2'd2: return vScr[l];
			default: return 8'h00;
		endcase
	endfunction

	// tile code from both bytes, then line in tile and pixel half
	function automatic logic [gaW-1:0] refGa(input logic l, input logic [8:0] h,
		input logic [7:0] v, input logic [8:0] hOff, input logic [7:0] vOff);
		logic [8:0] hs;
		logic [7:0] vs;
		logic [7:0] lo;
		logic [7:0] hi;
		hs = h + hOff;
		vs = v + vOff;
		lo = mirror[{l, vs[7:3], hs[8:3], 1'b0}];
		hi = mirror[{l, vs[7:3], hs[8:3], 1'b1}];
		return {hi[1:0], lo, vs[2:0], hs[2]};
	endfunction

	task automatic gaCheck(input string name, input logic [gaW-1:0] got,
		input logic [gaW-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "graphics address mismatch");
		end
	endtask

	task automatic priCheck(input string name, input logic [priW-1:0] got,
		input logic [priW-1:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "priority mismatch");
		end
	endtask

	task automatic byteCheck(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic bitCheck(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "control bit mismatch");
		end
	endtask

	// setup then access, waits for pReady with a limit
	task automatic busXfer(input logic wr, input logic [apbAddrW-1:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int tries;
		@(posedge CLK_6M);
		#2;
		pSel = 1'b1;
		pEnable = 1'b0;
		pWrite = wr;
		pAddr = addr;
		pWData = wdata;
		@(posedge CLK_6M);
		#2;
		pEnable = 1'b1;
		tries = 0;
		@(negedge CLK_6M);
		while (!pReady && tries < readyTimeout) begin
			@(negedge CLK_6M);
			tries++;
		end
		if (!pReady) begin
			$display("APB transfer to address %h never saw pReady", addr);
			$display("=== FAIL ===");
			$fatal(1, "pReady timeout");
		end
		rdata = pRData;
		// transfer completes on this edge
		@(posedge CLK_6M);
		#1;
		if (wr) begin
			modelWrite(addr, wdata);
		end
		#1;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
	endtask

	task automatic busWrite(input logic [apbAddrW-1:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		busXfer(1'b1, addr, data, unused);
	endtask

	task automatic busRead(input logic [apbAddrW-1:0] addr, output logic [7:0] data);
		busXfer(1'b0, addr, 8'h00, data);
	endtask

	// new scroll and priority for both layers
	task automatic randomScroll();
		logic [31:0] r;
		for (int l = 0; l < 2; l++) begin
			r = lcgNext();
			busWrite(regBase + 14'(l * 4), r[7:0]);
			busWrite(regBase + 14'(l * 4 + 1), r[15:8]);
			busWrite(regBase + 14'(l * 4 + 2), r[23:16]);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// sync drive, position tracking and compare
	//////////////////////////////////////////////////////////////////////

	// any sync change is an edge, so toggling marks each line
	initial begin : syncDrive
		int lines;
		lines = 0;
		forever begin
			repeat (linePeriod) @(posedge CLK_6M);
			#2;
			hSync = ~hSync;
			lines++;
			if (lines % linesPerFrame == 0) begin
				vSync = ~vSync;
			end
		end
	end

	always @(posedge CLK_6M or negedge rstN) begin : track
		logic hEdge;
		logic vEdge;
		if (!rstN) begin
			hPosT = '0;
			vPosT = '0;
			layerT = 1'b0;
			hPrev = 1'b0;
			vPrev = 1'b0;
			cycleCnt = 0;
		end else begin
			hEdge = hSync != hPrev;
			vEdge = vSync != vPrev;
			if (hEdge) begin
				hPosT = '0;
			end else if (layerT) begin
				hPosT = hPosT + 1'b1;
			end
			// vsync clear wins
			if (vEdge) begin
				vPosT = '0;
			end else if (hEdge) begin
				vPosT = vPosT + 1'b1;
			end
			layerT = ~layerT;
			hPrev = hSync;
			vPrev = vSync;
			cycleCnt++;
		end
	end

	// mid cycle, away from the drive and capture edges
	always @(negedge CLK_6M) begin : compare
		logic [hScrollW-1:0] hs;
		if (rstN) begin
			hs = hPosT + hScr[layerT];
			// ready only in the access phase
			bitCheck("pReady", pReady, pSel && pEnable);
			bitCheck("nibbleStrobe", nibbleStrobe, hs[2:0] == 3'd3);
			bitCheck("gaLayer", gaLayer, layerT);
			priCheck("gaPri", gaPri, priCopy[layerT]);
			// tile bytes fetched three pixels back in this line
			if (checking && nibbleStrobe && hPosT >= 4 && cycleCnt - lastWr >= quietCycles) begin
				gaCheck("ga", ga, refGa(layerT, hPosT, vPosT, hScr[layerT], vScr[layerT]));
				gaChecks++;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin : mainSeq
		logic [7:0] rd;
		logic [31:0] r;
		logic [7:0] vs;
		logic l;
		rstN = 1'b0;
		pSel = 1'b0;
		pEnable = 1'b0;
		pWrite = 1'b0;
		pAddr = '0;
		pWData = '0;
		hSync = 1'b0;
		vSync = 1'b0;
		checking = 1'b0;
		gaChecks = 0;
		lastWr = 0;
		lcgState = 32'hee3b0e30;
		for (int l0 = 0; l0 < 2; l0++) begin
			hScr[l0] = '0;
			vScr[l0] = '0;
			priCopy[l0] = '0;
		end
		repeat (3) @(posedge CLK_6M);
		#2 rstN = 1'b1;

		// fill every tile byte, then read all back
		for (int i = 0; i < (1 << ramAddrW); i++) begin
			r = lcgNext();
			busWrite(14'(i), r[23:16]);
		end
		for (int i = 0; i < (1 << ramAddrW); i++) begin
			busRead(14'(i), rd);
			byteCheck("pRData", rd, mirror[i]);
		end

		// all eight offsets, 3 and 7 unmapped
		for (int i = 0; i < 8; i++) begin
			r = lcgNext();
			busWrite(regBase + 14'(i), r[23:16]);
		end
		for (int i = 0; i < 8; i++) begin
			busRead(regBase + 14'(i), rd);
			byteCheck("pRData", rd, regExpect(regBase + 14'(i)));
		end

		// zero scroll over more than one frame
		for (int i = 0; i < 8; i++) begin
			busWrite(regBase + 14'(i), 8'h00);
		end
		checking = 1'b1;
		repeat (20 * linePeriod) @(posedge CLK_6M);

		// random scroll including bit 8
		for (int k = 0; k < 6; k++) begin
			randomScroll();
			repeat (3 * linePeriod) @(posedge CLK_6M);
		end

		// tile rewrites in the rows on screen, scroll changes between
		for (int k = 0; k < 80; k++) begin
			r = lcgNext();
			l = r[31];
			vs = vPosT + vScr[l];
			busWrite({1'b0, l, vs[7:3], r[29:24], r[23]}, r[15:8]);
			if (k % 10 == 9) begin
				randomScroll();
			end
			repeat (r[3:0]) @(posedge CLK_6M);
		end
		repeat (2 * linePeriod) @(posedge CLK_6M);

		if (gaChecks == 0) begin
			$display("no graphics address was ever compared");
			$display("=== FAIL ===");
			$fatal(1, "nothing checked");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

//--- sources.f
src/tilemapPkg.sv
src/scrollRegs.sv
src/videoTiming.sv
src/tileRam.sv
src/tileAddrGen.sv
src/tilemapTop.sv
dv/tilemapTb.sv

//--- src/scrollRegs.sv
`timescale 1ns/10ps

module scrollRegs (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [2:0] pAddr,
	input  logic [7:0] pWData,
	output logic [7:0] pRData,
	output logic pReady,
	output logic [tilemapPkg::hScrollW-1:0] hScroll0,
	output logic [tilemapPkg::hScrollW-1:0] hScroll1,
	output logic [tilemapPkg::vScrollW-1:0] vScroll0,
	output logic [tilemapPkg::vScrollW-1:0] vScroll1,
	output logic [tilemapPkg::priW-1:0] pri0,
	output logic [tilemapPkg::priW-1:0] pri1
);
	import tilemapPkg::*;

	// per layer state, index is the layer
	logic [hScrollW-1:0] hScroll [0:1];
	logic [vScrollW-1:0] vScroll [0:1];
	logic [priW-1:0] pri [0:1];
	logic regLayer;
	logic [1:0] regOff;
	logic wrEn;
	logic [7:0] rdMux;

	assign regLayer = pAddr[2];
	assign regOff = pAddr[1:0];
	// write lands in the access phase
	assign wrEn = pSel && pEnable && pWrite;

	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2; i++) begin
				hScroll[i] <= '0;
				vScroll[i] <= '0;
				pri[i] <= '0;
			end
		end else if (wrEn) begin
			case (regOff)
				regHLo: hScroll[regLayer][7:0] <= pWData;
				// scroll msb in bit 0, priority above it
				regHHi: begin
					hScroll[regLayer][hScrollW-1] <= pWData[0];
					pri[regLayer] <= pWData[priW:1];
				end
				regV: vScroll[regLayer] <= pWData;
				default: ;
			endcase
		end
	end

	// readback in the same packing, offset 3 reads zero
	always_comb begin
		case (regOff)
			regHLo: rdMux = hScroll[regLayer][7:0];
			regHHi: rdMux = {4'b0, pri[regLayer], hScroll[regLayer][hScrollW-1]};
			regV: rdMux = vScroll[regLayer];
			default: rdMux = '0;
		endcase
	end

	// sample on the setup edge so data is ready for access
	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			pRData <= '0;
		end else if (pSel && !pEnable) begin
			pRData <= rdMux;
		end
	end

	assign pReady = pSel && pEnable;

	assign hScroll0 = hScroll[0];
	assign hScroll1 = hScroll[1];
	assign vScroll0 = vScroll[0];
	assign vScroll1 = vScroll[1];
	assign pri0 = pri[0];
	assign pri1 = pri[1];

	// top level decode must gate enable together with select
	assert property (@(posedge CLK_6M) disable iff (!rstN) pEnable |-> pSel);

endmodule

//--- src/tileAddrGen.sv
`timescale 1ns/10ps

module tileAddrGen (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic [tilemapPkg::hScrollW-1:0] hPos,
	input  logic [tilemapPkg::vScrollW-1:0] vPos,
	input  logic layer,
	input  logic [tilemapPkg::hScrollW-1:0] hScroll0,
	input  logic [tilemapPkg::hScrollW-1:0] hScroll1,
	input  logic [tilemapPkg::vScrollW-1:0] vScroll0,
	input  logic [tilemapPkg::vScrollW-1:0] vScroll1,
	input  logic [tilemapPkg::priW-1:0] pri0,
	input  logic [tilemapPkg::priW-1:0] pri1,
	input  logic [7:0] vidData,
	output logic [tilemapPkg::ramAddrW-1:0] vidAddr,
	output logic [tilemapPkg::gaW-1:0] ga,
	output logic gaLayer,
	output logic [tilemapPkg::priW-1:0] gaPri,
	output logic nibbleStrobe
);
	import tilemapPkg::*;

	// offsets for the layer owning this slot
	logic [hScrollW-1:0] hOff;
	logic [vScrollW-1:0] vOff;
	// scrolled position of the current slot
	logic [hScrollW-1:0] hScrollL;
	logic [vScrollW-1:0] vScrollL;
	// tag of the read in flight
	logic tagLayer;
	logic tagLo;
	logic tagHi;
	// captured tile bytes, index is the layer
	logic [7:0] tdLo [0:1];
	logic [7:0] tdHi [0:1];

	//////////////////////////////////////////////////////////////////////
	// scroll addition
	//////////////////////////////////////////////////////////////////////

	assign hOff = layer ? hScroll1 : hScroll0;
	assign vOff = layer ? vScroll1 : vScroll0;

	// wraps around the 512 x 256 map
	assign hScrollL = hPos + hOff;
	assign vScrollL = vPos + vOff;

	// layer, row, column, byte select
	assign vidAddr = {layer, vScrollL[vScrollW-1:3], hScrollL[hScrollW-1:3], hScrollL[0]};

	//////////////////////////////////////////////////////////////////////
	// tile byte capture
	//////////////////////////////////////////////////////////////////////

	// tag follows the read by one cycle, same as the ram
	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			// opposite of slot 0 so the tag never matches the slot
			tagLayer <= 1'b1;
			tagLo <= 1'b0;
			tagHi <= 1'b0;
		end else begin
			tagLayer <= layer;
			tagLo <= hScrollL[2:0] == 3'd0;
			tagHi <= hScrollL[2:0] == 3'd1;
		end
	end

	// returned byte goes to the layer that asked for it
	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 2; i++) begin
				tdLo[i] <= '0;
				tdHi[i] <= '0;
			end
		end else begin
			if (tagLo) begin
				tdLo[tagLayer] <= vidData;
			end
			if (tagHi) begin
				tdHi[tagLayer] <= vidData;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// graphics rom address
	//////////////////////////////////////////////////////////////////////

	// tile code, line in tile, which half of the 8 pixels
	assign ga = {tdHi[layer][1:0], tdLo[layer], vScrollL[2:0], hScrollL[2]};
	assign gaLayer = layer;
	assign gaPri = layer ? pri1 : pri0;

	// both bytes in by phase 3
	assign nibbleStrobe = hScrollL[2:0] == 3'd3;

	// slot bit must alternate or bytes land in the wrong layer
	assert property (@(posedge CLK_6M) disable iff (!rstN) tagLayer != layer);

endmodule

//--- src/tileRam.sv
`timescale 1ns/10ps

module tileRam (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [tilemapPkg::ramAddrW-1:0] pAddr,
	input  logic [7:0] pWData,
	input  logic [tilemapPkg::ramAddrW-1:0] vidAddr,
	output logic [7:0] pRData,
	output logic pReady,
	output logic [7:0] vidData
);
	import tilemapPkg::*;

	// 2 layers x 32 rows x 64 columns x 2 bytes
	logic [7:0] mem [0:(1 << ramAddrW)-1];
	logic wrEn;
	logic setupPhase;

	assign wrEn = pSel && pEnable && pWrite;
	assign setupPhase = pSel && !pEnable;

	//////////////////////////////////////////////////////////////////////
	// cpu port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M) begin
		if (wrEn) begin
			mem[pAddr] <= pWData;
		end
	end

	// read fetched with the setup address, held through access
	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			pRData <= '0;
		end else if (setupPhase) begin
			pRData <= mem[pAddr];
		end
	end

	// no wait states
	assign pReady = pSel && pEnable;

	//////////////////////////////////////////////////////////////////////
	// video port
	//////////////////////////////////////////////////////////////////////

	// one cycle latency, free running
	always_ff @(posedge CLK_6M) begin
		vidData <= mem[vidAddr];
	end

	// the read data was fetched with the setup address
	assert property (@(posedge CLK_6M) disable iff (!rstN)
		setupPhase ##1 pEnable |-> $stable(pAddr));

endmodule

//--- src/tilemapPkg.sv
package tilemapPkg;

	//////////////////////////////////////////////////////////////////////
	// cpu address map
	//////////////////////////////////////////////////////////////////////

	// byte address as seen on apb
	localparam int apbAddrW = 14;

	// tile ram byte address
	// 12 layer, 11..7 tile row, 6..1 tile column, 0 byte select
	localparam int ramAddrW = 13;

	// scroll registers sit above the tile ram
	localparam logic [apbAddrW-1:0] regBase = 14'h2000;

	// offsets within one layer, address bit 2 picks the layer
	localparam logic [1:0] regHLo = 2'd0;
	localparam logic [1:0] regHHi = 2'd1;
	localparam logic [1:0] regV = 2'd2;

	//////////////////////////////////////////////////////////////////////
	// video side widths
	//////////////////////////////////////////////////////////////////////

	localparam int hScrollW = 9;
	localparam int vScrollW = 8;
	localparam int priW = 3;

	// graphics rom address per layer
	localparam int gaW = 14;

endpackage

//--- src/tilemapTop.sv
`timescale 1ns/10ps

module tilemapTop (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic pSel,
	input  logic pEnable,
	input  logic pWrite,
	input  logic [tilemapPkg::apbAddrW-1:0] pAddr,
	input  logic [7:0] pWData,
	input  logic hSync,
	input  logic vSync,
	output logic [7:0] pRData,
	output logic pReady,
	output logic [tilemapPkg::gaW-1:0] ga,
	output logic gaLayer,
	output logic [tilemapPkg::priW-1:0] gaPri,
	output logic nibbleStrobe
);
	import tilemapPkg::*;

	logic selRam;
	logic selReg;
	logic [7:0] ramRData;
	logic [7:0] regRData;
	logic ramReady;
	logic regReady;
	logic [hScrollW-1:0] hScroll0;
	logic [hScrollW-1:0] hScroll1;
	logic [vScrollW-1:0] vScroll0;
	logic [vScrollW-1:0] vScroll1;
	logic [priW-1:0] pri0;
	logic [priW-1:0] pri1;
	logic [hScrollW-1:0] hPos;
	logic [vScrollW-1:0] vPos;
	logic layer;
	logic [ramAddrW-1:0] vidAddr;
	logic [7:0] vidData;

	//////////////////////////////////////////////////////////////////////
	// apb decode
	//////////////////////////////////////////////////////////////////////

	// tile ram below regBase, registers from there up
	assign selReg = pAddr >= regBase;
	assign selRam = !selReg;

	assign pRData = selReg ? regRData : ramRData;
	assign pReady = selReg ? regReady : ramReady;

	scrollRegs uScrollRegs (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.pSel(pSel && selReg),
		.pEnable(pEnable && selReg),
		.pWrite(pWrite),
		.pAddr(pAddr[2:0]),
		.pWData(pWData),
		.pRData(regRData),
		.pReady(regReady),
		.hScroll0(hScroll0),
		.hScroll1(hScroll1),
		.vScroll0(vScroll0),
		.vScroll1(vScroll1),
		.pri0(pri0),
		.pri1(pri1)
	);

	tileRam uTileRam (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.pSel(pSel && selRam),
		.pEnable(pEnable && selRam),
		.pWrite(pWrite),
		.pAddr(pAddr[ramAddrW-1:0]),
		.pWData(pWData),
		.vidAddr(vidAddr),
		.pRData(ramRData),
		.pReady(ramReady),
		.vidData(vidData)
	);

	//////////////////////////////////////////////////////////////////////
	// video path
	//////////////////////////////////////////////////////////////////////

	videoTiming uVideoTiming (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.hSync(hSync),
		.vSync(vSync),
		.hPos(hPos),
		.vPos(vPos),
		.layer(layer)
	);

	tileAddrGen uTileAddrGen (
		.CLK_6M(CLK_6M),
		.rstN(rstN),
		.hPos(hPos),
		.vPos(vPos),
		.layer(layer),
		.hScroll0(hScroll0),
		.hScroll1(hScroll1),
		.vScroll0(vScroll0),
		.vScroll1(vScroll1),
		.pri0(pri0),
		.pri1(pri1),
		.vidData(vidData),
		.vidAddr(vidAddr),
		.ga(ga),
		.gaLayer(gaLayer),
		.gaPri(gaPri),
		.nibbleStrobe(nibbleStrobe)
	);

endmodule

//--- src/videoTiming.sv
`timescale 1ns/10ps

module videoTiming (
	input  logic CLK_6M,
	input  logic rstN,
	input  logic hSync,
	input  logic vSync,
	output logic [tilemapPkg::hScrollW-1:0] hPos,
	output logic [tilemapPkg::vScrollW-1:0] vPos,
	output logic layer
);
	import tilemapPkg::*;

	logic hSyncQ;
	logic vSyncQ;
	logic hEdge;
	logic vEdge;

	// either polarity, so any change counts as an edge
	assign hEdge = hSync != hSyncQ;
	assign vEdge = vSync != vSyncQ;

	//////////////////////////////////////////////////////////////////////
	// sync history and slot bit
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			hSyncQ <= 1'b0;
			vSyncQ <= 1'b0;
			layer <= 1'b0;
		end else begin
			hSyncQ <= hSync;
			vSyncQ <= vSync;
			// two layers share every pixel pair
			layer <= ~layer;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// pixel and line counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK_6M or negedge rstN) begin
		if (!rstN) begin
			hPos <= '0;
			vPos <= '0;
		end else begin
			if (hEdge) begin
				hPos <= '0;
			end else if (layer) begin
				// advance after slot 1 so both layers see the same pixel
				hPos <= hPos + 1'b1;
			end
			// vsync wins over the line advance
			if (vEdge) begin
				vPos <= '0;
			end else if (hEdge) begin
				vPos <= vPos + 1'b1;
			end
		end
	end

	// slot 0 holds the pixel unless the line restarts
	assert property (@(posedge CLK_6M) disable iff (!rstN)
		(!layer && (hSync == hSyncQ)) |=> $stable(hPos));

endmodule
